/* source/spi_defines.svh */
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// ******************************
// frame format
// ******************************

`define SPI_CMD_WIDTH  12  // flag + address + data
`define SPI_READ_WIDTH 8
`define SPI_HDR_WIDTH  4   // flag + address, sent before read data

// ******************************
// bus timing, in clk cycles
// ******************************

`define SPI_HALF_DIV   4   // sclk half period
`define SPI_CS_GAP     2   // cs high before cmd_rdy returns

`endif

/* source/spi_cmd_pkg.sv */
`include "spi_defines.svh"

package spi_cmd_pkg;

  // ******************************
  // command word layout
  // ******************************

  typedef logic [`SPI_CMD_WIDTH-1:0] cmd_t;   // bit 11 flag, 10:8 addr, 7:0 data

  typedef logic [`SPI_READ_WIDTH-1:0] rdata_t;

  typedef logic [2:0] reg_addr_t;

  // bit 11 of the command selects the operation
  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } op_e;

endpackage

/* source/spi_bus_pkg.sv */
package spi_bus_pkg;

  // ******************************
  // frame sequencing
  // ******************************

  typedef enum logic [1:0]
  {
    ph_idle  = 2'd0,  // waiting for a command
    ph_shift = 2'd1,  // cs low, sclk running
    ph_gap   = 2'd2   // cs high, cmd_rdy held low
  } phase_e;

  // counts sclk periods, up to 12
  typedef logic [3:0] bit_cnt_t;

endpackage

/* source/spi_sclk_gen.sv */
`timescale 1ns/1ps

module spi_sclk_gen #(
  parameter int HALF_DIV = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic en,
  output logic sclk,
  output logic rise,
  output logic fall
);

  localparam int CNT_W = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

  logic [CNT_W-1:0] half_cnt;
  logic             toggle;

  // strobes mark the clk edge on which sclk changes level
  assign toggle = en && (half_cnt == CNT_W'(HALF_DIV - 1));
  assign rise   = toggle && !sclk;
  assign fall   = toggle && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      sclk     <= 1'b0;
    end
    else if (!en)
    begin
      half_cnt <= '0;  // restart with a low half period
      sclk     <= 1'b0;
    end
    else if (toggle)
    begin
      half_cnt <= '0;
      sclk     <= ~sclk;
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // ******************************
  // checks
  // ******************************

  a_sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
    !en |=> !sclk)
    else $error("sclk not low one cycle after en dropped");

endmodule

/* source/spi_master.sv */
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_master (
  input  logic                clk,
  input  logic                rst_n,
  input  spi_cmd_pkg::cmd_t   cmd_in,
  input  logic                cmd_vld,
  input  logic                miso,
  input  logic                rise,
  input  logic                fall,
  output logic                cmd_rdy,
  output logic                cs,
  output logic                mosi,
  output logic                sclk_en,
  output logic                read_vld,
  output spi_cmd_pkg::rdata_t read_data
);

  localparam int GAP_W = $clog2(`SPI_CS_GAP + 1);

  spi_bus_pkg::phase_e   phase;
  spi_bus_pkg::bit_cnt_t bit_cnt;   // rises seen in this frame
  spi_cmd_pkg::op_e      op;
  spi_cmd_pkg::cmd_t     shift_buf;
  spi_cmd_pkg::rdata_t   rx_shift;
  logic [GAP_W-1:0]      gap_cnt;
  logic                  accept;
  logic                  shifting;
  logic                  last_fall;
  logic                  in_data;   // header already sent

  assign accept    = cmd_vld && cmd_rdy;
  assign shifting  = (phase == spi_bus_pkg::ph_shift);
  assign last_fall = shifting && fall
                     && (bit_cnt == spi_bus_pkg::bit_cnt_t'(`SPI_CMD_WIDTH));
  assign in_data   = (bit_cnt >= spi_bus_pkg::bit_cnt_t'(`SPI_HDR_WIDTH));

  // ******************************
  // phase FSM and bus outputs
  // ******************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase     <= spi_bus_pkg::ph_idle;
      bit_cnt   <= '0;
      op        <= spi_cmd_pkg::op_read;
      gap_cnt   <= '0;
      cmd_rdy   <= 1'b1;
      cs        <= 1'b1;
      mosi      <= 1'b0;
      sclk_en   <= 1'b0;
      read_vld  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (phase)
        spi_bus_pkg::ph_idle:
        begin
          if (accept)
          begin
            phase   <= spi_bus_pkg::ph_shift;
            op      <= spi_cmd_pkg::op_e'(cmd_in[`SPI_CMD_WIDTH-1]);
            bit_cnt <= '0;
            cmd_rdy <= 1'b0;
            cs      <= 1'b0;
            sclk_en <= 1'b1;
            mosi    <= cmd_in[`SPI_CMD_WIDTH-1];  // flag bit leads
          end
        end
        spi_bus_pkg::ph_shift:
        begin
          if (rise)
            bit_cnt <= bit_cnt + 1'b1;
          if (last_fall)
          begin
            phase     <= spi_bus_pkg::ph_gap;
            gap_cnt   <= '0;
            cs        <= 1'b1;
            sclk_en   <= 1'b0;
            mosi      <= 1'b0;
            read_vld  <= (op == spi_cmd_pkg::op_read);
            if (op == spi_cmd_pkg::op_read)
              read_data <= rx_shift;
          end
          else if (fall)
          begin
            if (op == spi_cmd_pkg::op_read && in_data)
              mosi <= 1'b0;  // read turnaround, mosi idles
            else
              mosi <= shift_buf[`SPI_CMD_WIDTH-1];
          end
        end
        spi_bus_pkg::ph_gap:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == GAP_W'(`SPI_CS_GAP - 1))
          begin
            phase   <= spi_bus_pkg::ph_idle;
            cmd_rdy <= 1'b1;
          end
        end
        default:
          phase <= spi_bus_pkg::ph_idle;
      endcase
    end
  end

  // ******************************
  // shift registers
  // ******************************

  always_ff @(posedge clk)
  begin
    if (accept)
      shift_buf <= cmd_in << 1;  // bit 11 already on mosi
    else if (shifting && fall)
      shift_buf <= shift_buf << 1;

    if (shifting && rise && op == spi_cmd_pkg::op_read && in_data)
      rx_shift <= {rx_shift[`SPI_READ_WIDTH-2:0], miso};  // msb first
  end

  // ******************************
  // checks
  // ******************************

  a_rdy_cs_high: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> cs)
    else $error("cmd_rdy high while cs low");

  a_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
    else $error("read_vld longer than one cycle");

  a_cs_in_shift: assert property (@(posedge clk) disable iff (!rst_n)
    shifting |-> !cs)
    else $error("cs high during shift phase");

endmodule

/* source/spi_ctrl_top.sv */
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_ctrl_top (
  input  logic                clk,
  input  logic                rst_n,
  input  spi_cmd_pkg::cmd_t   cmd_in,
  input  logic                cmd_vld,
  input  logic                miso,
  output logic                cmd_rdy,
  output logic                sclk,
  output logic                cs,
  output logic                mosi,
  output logic                read_vld,
  output spi_cmd_pkg::rdata_t read_data
);

  logic sclk_en;
  logic rise;
  logic fall;

  spi_sclk_gen #(
    .HALF_DIV (`SPI_HALF_DIV)
  ) u_sclk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (sclk_en),
    .sclk  (sclk),
    .rise  (rise),
    .fall  (fall)
  );

  spi_master u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .rise      (rise),
    .fall      (fall),
    .cmd_rdy   (cmd_rdy),
    .cs        (cs),
    .mosi      (mosi),
    .sclk_en   (sclk_en),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

/* tests/spi_slave_model.sv */
`timescale 1ns/1ps

module spi_slave_model (
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  logic [7:0]  regs [0:7];
  logic [11:0] rx_bits;
  logic [3:0]  bit_cnt;  // sclk rises in this frame
  logic [2:0]  rd_addr;
  logic        rd_op;

  initial
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = 8'hA0 + 8'(i);  // reset contents
    miso = 1'b0;
  end

  always @(posedge sclk or posedge cs)
  begin
    if (cs)
    begin
      bit_cnt = 4'd0;
      rd_op   = 1'b0;
    end
    else
    begin
      rx_bits = {rx_bits[10:0], mosi};
      bit_cnt = bit_cnt + 4'd1;
      if (bit_cnt == 4'd4)
      begin
        rd_op   = !rx_bits[3];  // flag low means read
        rd_addr = rx_bits[2:0];
      end
      if (bit_cnt == 4'd12 && rx_bits[11])
        regs[rx_bits[10:8]] = rx_bits[7:0];
    end
  end

  // read byte goes out msb first, one bit after each fall past the header
  always @(negedge sclk)
  begin
    if (rd_op && bit_cnt >= 4'd4 && bit_cnt < 4'd12)
      miso = regs[rd_addr][3'(4'd11 - bit_cnt)];
  end

endmodule

/* tests/spi_checker.sv */
`timescale 1ns/1ps
`include "spi_defines.svh"

module spi_checker (
  input logic                clk,
  input logic                rst_n,
  input logic                cs,
  input logic                sclk,
  input logic                mosi,
  input logic                cmd_rdy,
  input logic                read_vld,
  input spi_cmd_pkg::rdata_t read_data
);

  int                err_cnt     = 0;
  int                test_cnt    = 0;
  int                frame_cnt   = 0;
  int                rise_cnt    = 0;
  int                cs_high_cnt = 0;  // samples since cs went high
  int                start_err   = 0;
  logic              idle_done   = 1'b0;
  logic              prev_cs     = 1'b1;
  logic              prev_sclk   = 1'b0;
  logic              prev_rdy    = 1'b1;
  spi_cmd_pkg::cmd_t frame_bits  = '0;  // mosi seen on each sclk rise

  task automatic mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic report(input string name);
    test_cnt++;
    $display("test %0d %s: %s", test_cnt, name, (err_cnt == start_err) ? "ok" : "failed");
  endtask

  // expected values come from the table entry being applied
  task automatic end_of_frame();
    spi_cmd_pkg::cmd_t exp_cmd;
    spi_cmd_pkg::cmd_t exp_frame;
    logic              is_read;
    exp_cmd   = tb_spi_top.cur_cmd;
    is_read   = (spi_cmd_pkg::op_e'(exp_cmd[`SPI_CMD_WIDTH-1]) == spi_cmd_pkg::op_read);
    exp_frame = is_read ? {exp_cmd[`SPI_CMD_WIDTH-1 -: `SPI_HDR_WIDTH], `SPI_READ_WIDTH'(0)}
                        : exp_cmd;  // mosi idles low after a read header
    if (rise_cnt != `SPI_CMD_WIDTH)
      mismatch($sformatf("%0d sclk rises in frame, expected %0d", rise_cnt, `SPI_CMD_WIDTH));
    if (frame_bits != exp_frame)
      mismatch($sformatf("mosi frame %h, expected %h", frame_bits, exp_frame));
    if (read_vld != is_read)
      mismatch($sformatf("read_vld %b at frame end, expected %b", read_vld, is_read));
    if (is_read && read_data != tb_spi_top.cur_exp)
      mismatch($sformatf("read_data %h, expected %h", read_data, tb_spi_top.cur_exp));
    report($sformatf("%s cmd %h", is_read ? "read" : "write", exp_cmd));
  endtask

  task automatic check_frame_total(input int accepted);
    start_err = err_cnt;
    if (frame_cnt != accepted)
      mismatch($sformatf("%0d frames on the bus, %0d commands accepted", frame_cnt, accepted));
    report("frame count");
    $display("tests %0d, frames %0d, mismatches %0d", test_cnt, frame_cnt, err_cnt);
  endtask

  // ******************************
  // bus monitor, mid-cycle samples
  // ******************************

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (!idle_done)
      begin
        idle_done = 1'b1;
        if (!cs || sclk || !cmd_rdy || read_vld)
          mismatch("outputs not idle after reset");
        report("reset state");
      end
      if (prev_cs && !cs)
      begin
        frame_cnt++;
        rise_cnt  = 0;
        start_err = err_cnt;
      end
      if (!cs && sclk && !prev_sclk)
      begin
        frame_bits = {frame_bits[`SPI_CMD_WIDTH-2:0], mosi};
        rise_cnt++;
      end
      if (!cs && cmd_rdy)
        mismatch("cmd_rdy high while cs low");
      if (read_vld && !(cs && !prev_cs))
        mismatch("read_vld high outside the end of a frame");
      if (cs && !prev_cs)
        end_of_frame();
      cs_high_cnt = cs ? cs_high_cnt + 1 : 0;
      if (cmd_rdy && !prev_rdy && cs_high_cnt <= `SPI_CS_GAP)
        mismatch($sformatf("cmd_rdy rose %0d cycles after cs", cs_high_cnt - 1));
      prev_cs   = cs;
      prev_sclk = sclk;
      prev_rdy  = cmd_rdy;
    end
  end

endmodule

/* tests/tb_spi_top.sv */
`timescale 1ns/1ps

module tb_spi_top;

  localparam int RDY_TIMEOUT = 400;  // about four frame lengths in clk cycles

  logic                clk;
  logic                rst_n;
  spi_cmd_pkg::cmd_t   cmd_in;
  logic                cmd_vld;
  logic                miso;
  logic                cmd_rdy;
  logic                sclk;
  logic                cs;
  logic                mosi;
  logic                read_vld;
  spi_cmd_pkg::rdata_t read_data;

  spi_cmd_pkg::cmd_t   tab_cmd [$];
  spi_cmd_pkg::rdata_t tab_exp [$];
  bit                  tab_poke [$];  // strobe cmd_vld again mid-frame
  spi_cmd_pkg::rdata_t ref_regs [0:7];
  spi_cmd_pkg::cmd_t   cur_cmd;
  spi_cmd_pkg::rdata_t cur_exp;
  logic [31:0]         lfsr_state;
  logic                aborted;

  spi_ctrl_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model slave (.sclk(sclk), .cs(cs), .mosi(mosi), .miso(miso));

  spi_checker chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .cs        (cs),
    .sclk      (sclk),
    .mosi      (mosi),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  always #20 clk = ~clk;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic lfsr_bit();
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    return lfsr_state[0];
  endfunction

  function automatic spi_cmd_pkg::rdata_t rand_byte();
    spi_cmd_pkg::rdata_t b;
    b = '0;
    for (int i = 0; i < 8; i++)
      b = {b[6:0], lfsr_bit()};
    return b;
  endfunction

  task automatic add_write(input spi_cmd_pkg::reg_addr_t addr, input spi_cmd_pkg::rdata_t data,
                           input bit poke);
    tab_cmd.push_back({spi_cmd_pkg::op_write, addr, data});
    tab_exp.push_back('0);
    tab_poke.push_back(poke);
    ref_regs[addr] = data;
  endtask

  task automatic add_read(input spi_cmd_pkg::reg_addr_t addr, input bit poke);
    tab_cmd.push_back({spi_cmd_pkg::op_read, addr, 8'hff});  // data field unused on reads
    tab_exp.push_back(ref_regs[addr]);
    tab_poke.push_back(poke);
  endtask

  task automatic wait_rdy(output bit ok);
    int n;
    n = 0;
    while (!cmd_rdy && n < RDY_TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    ok = cmd_rdy;
  endtask

  initial
  begin
    bit ok;
    clk        = 1'b0;
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    aborted    = 1'b0;
    cur_cmd    = '0;
    cur_exp    = '0;
    lfsr_state = 32'h13d24bb8;
    for (int i = 0; i < 8; i++)
      ref_regs[i] = 8'hA0 + 8'(i);

    // ******************************
    // stimulus table
    // ******************************
    add_read(3'd3, 1'b0);  // untouched registers
    add_read(3'd6, 1'b0);
    add_write(3'd1, rand_byte(), 1'b0);
    add_write(3'd2, rand_byte(), 1'b1);
    add_write(3'd5, rand_byte(), 1'b0);
    add_write(3'd2, rand_byte(), 1'b0);  // overwrite
    add_read(3'd1, 1'b0);
    add_read(3'd2, 1'b1);
    add_read(3'd5, 1'b0);
    add_write(3'd7, 8'h3c, 1'b0);
    add_read(3'd7, 1'b0);
    add_read(3'd0, 1'b0);

    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < tab_cmd.size() && !aborted; i++)
    begin
      @(negedge clk);
      wait_rdy(ok);
      if (!ok)
      begin
        $display("timeout: cmd_rdy never went high before entry %0d", i);
        aborted = 1'b1;
      end
      else
      begin
        cur_cmd = tab_cmd[i];
        cur_exp = tab_exp[i];
        cmd_in  = tab_cmd[i];
        cmd_vld = 1'b1;
        @(negedge clk);
        cmd_vld = 1'b0;
        if (tab_poke[i])
        begin
          repeat (10) @(negedge clk);
          cmd_in  = ~tab_cmd[i];  // ignored while the frame is running
          cmd_vld = 1'b1;
          @(negedge clk);
          cmd_vld = 1'b0;
        end
        wait_rdy(ok);
        if (!ok)
        begin
          $display("timeout: frame for entry %0d never finished", i);
          aborted = 1'b1;
        end
      end
    end

    chk.check_frame_total(tab_cmd.size());
    if (aborted || chk.err_cnt != 0)
      $display("TEST RESULT: FAIL");
    else
      $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* build.f */
+incdir+source
source/spi_cmd_pkg.sv
source/spi_bus_pkg.sv
source/spi_sclk_gen.sv
source/spi_master.sv
source/spi_ctrl_top.sv
tests/spi_slave_model.sv
tests/spi_checker.sv
tests/tb_spi_top.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_spi_top
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = TEST RESULT: FAIL
PASS_MSG = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
